// ==== bank_input_router.sv ====
// routes each active ADC channel to its banks and chains spare banks behind full ones
`timescale 1ns/1ns

module bank_input_router
  import sample_buffer_pkg::*;
#(
  parameter int CHANNELS = 8
) (
  input  logic                         clk,
  input  logic         [CHANNELS-1:0]  adc_valid,
  input  sample_word_t [CHANNELS-1:0]  adc_data,
  input  logic         [MODE_WIDTH-1:0] banking_mode,
  input  logic         [CHANNELS-1:0]  bank_full,
  input  logic         [CHANNELS-1:0]  full_latch,
  output logic         [CHANNELS-1:0]  bank_valid,
  output sample_word_t [CHANNELS-1:0]  bank_data
);

  localparam int SW = $clog2(CHANNELS);
  localparam int NW = SW + 1;

  logic [NW-1:0]                n_active;
  logic [CHANNELS-1:0][SW-1:0]  src_idx;
  logic [CHANNELS-1:0]          valid_d;

  assign n_active = NW'(1) << banking_mode;

  // bank i listens to channel i mod n_active
  // n_active is a power of two, so the modulo is a mask
  always_comb begin
    for (int i = 0; i < CHANNELS; i++) begin
      src_idx[i] = SW'(i) & SW'(n_active - 1'b1);
    end
  end

  // one register stage on both data and valid keeps them aligned
  always_ff @(posedge clk) begin
    for (int i = 0; i < CHANNELS; i++) begin
      valid_d[i]   <= adc_valid[src_idx[i]];
      bank_data[i] <= adc_data[src_idx[i]];
    end
  end

  // a bank at or beyond n_active only exists when fewer channels are active
  // it sits behind bank i - n_active of the same channel and may only
  // write once that bank has filled
  always_comb begin
    for (int i = 0; i < CHANNELS; i++) begin
      if (i >= int'(n_active)) begin
        bank_valid[i] = valid_d[i] &
                        (bank_full[i - int'(n_active)] | full_latch[i - int'(n_active)]);
      end else begin
        bank_valid[i] = valid_d[i];
      end
    end
  end

endmodule

// ==== capture_control.sv ====
// decodes the config strobe and decides when all banks stop capturing
`timescale 1ns/1ns

module capture_control
  import sample_buffer_pkg::*;
#(
  parameter int CHANNELS = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cfg_valid,
  input  config_t               cfg,
  input  logic                  stop_aux,
  input  logic [CHANNELS-1:0]   bank_full,
  input  logic                  readout_done,
  output logic                  start,
  output logic                  stop_banks,
  output logic [MODE_WIDTH-1:0] banking_mode,
  output logic                  capture_started,
  output logic                  buffer_full,
  output logic [CHANNELS-1:0]   full_latch
);

  // one extra bit so all CHANNELS can be active
  localparam int NW = $clog2(CHANNELS) + 1;

  logic                stop;
  logic [NW-1:0]       n_active;
  logic [CHANNELS-1:0] full_mask;

  assign n_active = NW'(1) << banking_mode;

  // start and stop are one-cycle pulses, the mode stays until the next config
  always_ff @(posedge clk) begin
    if (reset) begin
      start        <= 1'b0;
      stop         <= 1'b0;
      banking_mode <= '0;
    end else if (cfg_valid) begin
      start        <= cfg.start;
      stop         <= cfg.stop;
      banking_mode <= cfg.banking_mode;
    end else begin
      start <= 1'b0;
      stop  <= 1'b0;
    end
  end

  assign capture_started = start;

  // the last n_active banks end each chain, so one of them filling up
  // means its channel has no room left
  always_comb begin
    for (int i = 0; i < CHANNELS; i++) begin
      full_mask[i] = (i >= CHANNELS - int'(n_active));
    end
  end

  assign buffer_full = |(full_mask & bank_full);
  assign stop_banks  = stop || stop_aux || buffer_full;

  // a bank drops full when it returns to idle after its readout
  // and the latch keeps it set so the next bank in the chain stays enabled
  // for as long as sparse input is still arriving
  always_ff @(posedge clk) begin
    if (reset) begin
      full_latch <= '0;
    end else if (readout_done) begin
      full_latch <= '0;
    end else begin
      full_latch <= full_latch | bank_full;
    end
  end

  // a mode beyond log2(CHANNELS) would ask for more channels than exist
  assert property (@(posedge clk) disable iff (reset)
    banking_mode <= MODE_WIDTH'($clog2(CHANNELS)));

endmodule

// ==== readout_mux.sv ====
// walks the banks in order and feeds their words into one registered output stream
`timescale 1ns/1ns

module readout_mux
  import sample_buffer_pkg::*;
#(
  parameter int CHANNELS = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  logic    [MODE_WIDTH-1:0]        banking_mode,
  input  stream_t [CHANNELS-1:0]          bank_out,
  input  logic    [CHANNELS-1:0]          bank_first,
  input  logic                            out_ready,
  output logic    [CHANNELS-1:0]          bank_ready,
  output stream_t                         out,
  output logic                            readout_done
);

  localparam int SW = $clog2(CHANNELS);
  localparam int NW = SW + 1;

  logic [SW-1:0] bank_select;
  logic [NW-1:0] n_active;
  stream_t       sel;
  bank_word_u    id_word;
  bank_word_u    out_data;
  logic          out_valid;
  logic          out_last;
  logic          final_bank;
  logic          sel_done;

  assign n_active   = NW'(1) << banking_mode;
  assign sel        = bank_out[bank_select];
  assign final_bank = (bank_select == SW'(CHANNELS - 1));
  assign sel_done   = sel.valid && sel.last && out_ready;

  // the channel a bank belongs to replaces the bank's zero ID word
  assign id_word.header = WORD_WIDTH'(bank_select & SW'(n_active - 1'b1));

  // every bank except the selected one is held off
  always_comb begin
    for (int i = 0; i < CHANNELS; i++) begin
      bank_ready[i] = (SW'(i) == bank_select) && out_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bank_select <= '0;
    end else if (start) begin
      bank_select <= '0;
    end else if (sel_done) begin
      bank_select <= final_bank ? '0 : bank_select + 1'b1;
    end
  end

  // a bank's last only ends the whole stream when it comes from the final bank
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (out_ready) begin
      out_valid <= sel.valid;
      out_last  <= final_bank && sel.valid && sel.last;
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready) begin
      out_data <= bank_first[bank_select] ? id_word : sel.data;
    end
  end

  assign out          = '{data: out_data, valid: out_valid, last: out_last};
  assign readout_done = out_valid && out_last && out_ready;

  // while the sink stalls the selected bank keeps offering the same word
  // and the output register holds its word, so nothing is lost or taken twice
  assert property (@(posedge clk) disable iff (reset)
    !out_ready && !start && sel.valid |=> $stable(sel) && $stable(out));

endmodule

// ==== sample_buffer.sv ====
// top level of the multi-bank ADC capture buffer, connects control, router, banks and readout
`timescale 1ns/1ns

module sample_buffer
  import sample_buffer_pkg::*;
#(
  parameter int CHANNELS     = 8,
  parameter int BUFFER_DEPTH = 8192
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic         [CHANNELS-1:0] adc_valid,
  input  sample_word_t [CHANNELS-1:0] adc_data,
  input  logic                        cfg_valid,
  input  config_t                     cfg,
  input  logic                        stop_aux,
  output stream_t                     out,
  input  logic                        out_ready,
  output logic                        capture_started,
  output logic                        buffer_full
);

  logic                         start;
  logic                         stop_banks;
  logic         [MODE_WIDTH-1:0] banking_mode;
  logic         [CHANNELS-1:0]  full_latch;
  logic         [CHANNELS-1:0]  bank_full;
  logic         [CHANNELS-1:0]  bank_first;
  logic         [CHANNELS-1:0]  bank_ready;
  logic         [CHANNELS-1:0]  bank_valid;
  sample_word_t [CHANNELS-1:0]  bank_data;
  stream_t      [CHANNELS-1:0]  bank_out;
  logic                         readout_done;

  capture_control #(
    .CHANNELS(CHANNELS)
  ) u_control (
    .clk             (clk),
    .reset           (reset),
    .cfg_valid       (cfg_valid),
    .cfg             (cfg),
    .stop_aux        (stop_aux),
    .bank_full       (bank_full),
    .readout_done    (readout_done),
    .start           (start),
    .stop_banks      (stop_banks),
    .banking_mode    (banking_mode),
    .capture_started (capture_started),
    .buffer_full     (buffer_full),
    .full_latch      (full_latch)
  );

  bank_input_router #(
    .CHANNELS(CHANNELS)
  ) u_router (
    .clk          (clk),
    .adc_valid    (adc_valid),
    .adc_data     (adc_data),
    .banking_mode (banking_mode),
    .bank_full    (bank_full),
    .full_latch   (full_latch),
    .bank_valid   (bank_valid),
    .bank_data    (bank_data)
  );

  // one bank per channel, all started and stopped together
  for (genvar i = 0; i < CHANNELS; i++) begin : g_bank
    sample_buffer_bank #(
      .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_bank (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (bank_valid[i]),
      .in_data   (bank_data[i]),
      .start     (start),
      .stop      (stop_banks),
      .out_ready (bank_ready[i]),
      .out       (bank_out[i]),
      .full      (bank_full[i]),
      .first     (bank_first[i])
    );
  end

  readout_mux #(
    .CHANNELS(CHANNELS)
  ) u_readout (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .banking_mode (banking_mode),
    .bank_out     (bank_out),
    .bank_first   (bank_first),
    .out_ready    (out_ready),
    .bank_ready   (bank_ready),
    .out          (out),
    .readout_done (readout_done)
  );

endmodule

// ==== sample_buffer_bank.sv ====
// one capture buffer bank that stores words during capture and then streams ID, count and samples
`timescale 1ns/1ns

module sample_buffer_bank
  import sample_buffer_pkg::*;
#(
  parameter int BUFFER_DEPTH = 1024
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         in_valid,
  input  sample_word_t in_data,
  input  logic         start,
  input  logic         stop,
  input  logic         out_ready,
  output stream_t      out,
  output logic         full,
  output logic         first
);

  localparam int AW = $clog2(BUFFER_DEPTH);
  // one extra bit so the count can reach BUFFER_DEPTH itself
  localparam int CW = AW + 1;

  typedef enum logic [2:0] {
    IDLE,
    CAPTURE,
    SEND_ID,
    SEND_COUNT,
    SEND_SAMPLES
  } state_t;

  state_t state;

  sample_word_t  mem [BUFFER_DEPTH];
  sample_word_t  mem_q;
  logic [CW-1:0] wr_count;
  logic [CW-1:0] rd_count;

  // read stage between the memory and the output register
  logic q_valid;
  logic q_last;

  bank_word_u out_data;
  logic       out_valid;
  logic       out_last;

  logic wr_en;
  logic leave_capture;
  logic take_out;
  logic out_free;
  logic load_sample;
  logic issue;

  assign wr_en = (state == CAPTURE) && in_valid;

  // capture ends on a stop request or on the write into the last location
  assign leave_capture = (state == CAPTURE) &&
                         (stop || (wr_en && (wr_count == CW'(BUFFER_DEPTH - 1))));

  assign take_out = out_valid && out_ready;
  assign out_free = !out_valid || out_ready;

  // the read stage moves into the output register once the count word leaves,
  // and after that whenever the output register is free
  assign load_sample = ((state == SEND_COUNT) && take_out) ||
                       ((state == SEND_SAMPLES) && out_free);

  // reads start as soon as capture is over so the first sample waits ready
  // behind the two header words
  assign issue = (state inside {SEND_ID, SEND_COUNT, SEND_SAMPLES}) &&
                 (rd_count != wr_count) && (!q_valid || load_sample);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= CAPTURE;
          end
        end
        CAPTURE: begin
          if (leave_capture) begin
            state <= SEND_ID;
          end
        end
        SEND_ID: begin
          if (take_out) begin
            state <= SEND_COUNT;
          end
        end
        SEND_COUNT: begin
          // an empty bank ends its readout with the count word
          if (take_out) begin
            state <= out_last ? IDLE : SEND_SAMPLES;
          end
        end
        SEND_SAMPLES: begin
          if (take_out && out_last) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_count  <= '0;
      rd_count  <= '0;
      full      <= 1'b0;
      first     <= 1'b0;
      q_valid   <= 1'b0;
      q_last    <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      // counters and full clear once the previous readout has finished
      if (state == IDLE) begin
        wr_count <= '0;
        rd_count <= '0;
        full     <= 1'b0;
      end
      if (wr_en) begin
        wr_count <= wr_count + 1'b1;
        if (wr_count == CW'(BUFFER_DEPTH - 1)) begin
          full <= 1'b1;
        end
      end
      if (issue) begin
        rd_count <= rd_count + 1'b1;
        q_valid  <= 1'b1;
        q_last   <= (rd_count + 1'b1 == wr_count);
      end else if (load_sample) begin
        q_valid <= 1'b0;
        q_last  <= 1'b0;
      end
      // first flags the ID word so readout_mux can put the channel in its place
      if (leave_capture) begin
        out_valid <= 1'b1;
        out_last  <= 1'b0;
        first     <= 1'b1;
      end else if ((state == SEND_ID) && take_out) begin
        out_last <= (wr_count == '0);
        first    <= 1'b0;
      end else if (load_sample) begin
        out_valid <= q_valid;
        out_last  <= q_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_count[AW-1:0]] <= in_data;
    end
    if (issue) begin
      mem_q <= mem[rd_count[AW-1:0]];
    end
  end

  // the ID word leaves as zero and the count is the number of words written
  always_ff @(posedge clk) begin
    if (leave_capture) begin
      out_data.header <= '0;
    end else if ((state == SEND_ID) && take_out) begin
      out_data.header <= WORD_WIDTH'(wr_count);
    end else if (load_sample) begin
      out_data.samples <= mem_q;
    end
  end

  assign out = '{data: out_data, valid: out_valid, last: out_last};

  // a write only lands during capture and never beyond the last location of the bank
  assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !full && (wr_count < CW'(BUFFER_DEPTH)));

endmodule

// ==== sample_buffer_pkg.sv ====
// shared word shape, stream structs and config layout, imported by every capture buffer module
package sample_buffer_pkg;

  // each ADC channel delivers this many samples per clock in one wide word
  localparam int PARALLEL_SAMPLES = 4;

  // bits per sample as stored in the banks
  localparam int SAMPLE_WIDTH = 16;

  // width of one stored word and of every word on the output stream
  localparam int WORD_WIDTH = PARALLEL_SAMPLES * SAMPLE_WIDTH;

  // banking mode field width, enough for up to 8 channels
  localparam int MODE_WIDTH = 3;

  // a single sample value
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // one parallel word of samples as it arrives from a channel
  typedef logic [WORD_WIDTH-1:0] sample_word_t;

  // a stream word is read two ways:
  // captured data is PARALLEL_SAMPLES samples with sample 0 in the low bits,
  // while the ID and count words use one field with unused upper bits zero
  typedef union packed {
    sample_t [PARALLEL_SAMPLES-1:0] samples;
    logic [WORD_WIDTH-1:0]          header;
  } bank_word_u;

  // output stream word with its qualifiers
  // the handshake ready travels separately against the flow
  typedef struct packed {
    bank_word_u data;
    logic       valid;
    logic       last;
  } stream_t;

  // configuration word, sampled when cfg_valid is high
  // banking_mode n selects 2**n active channels
  // start and stop are taken as one-cycle requests
  typedef struct packed {
    logic [MODE_WIDTH-1:0] banking_mode;
    logic                  start;
    logic                  stop;
  } config_t;

endpackage

// ==== sample_buffer_tb.sv ====
// testbench for the capture buffer that runs capture and readout rounds against a model
`timescale 1ns/1ns

module sample_buffer_tb
  import sample_buffer_pkg::*;
();

  localparam int CHANNELS     = 4;
  localparam int BUFFER_DEPTH = 8;
  localparam int TIMEOUT      = 2000;

  // one predicted output word with its last flag
  typedef struct packed {
    logic [WORD_WIDTH-1:0] data;
    logic                  last;
  } expect_t;

  logic                        clk;
  logic                        reset;
  logic         [CHANNELS-1:0] adc_valid;
  sample_word_t [CHANNELS-1:0] adc_data;
  logic                        cfg_valid;
  config_t                     cfg;
  logic                        stop_aux;
  stream_t                     out;
  logic                        out_ready;
  logic                        capture_started;
  logic                        buffer_full;

  integer       seed;
  int           err_count;
  expect_t      exp_q[$];
  expect_t      exp_front;
  logic         exp_avail;
  // every word each channel presented while its banks could take it
  sample_word_t sent_q[CHANNELS][$];

  sample_buffer #(
    .CHANNELS     (CHANNELS),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) dut0 (
    .clk             (clk),
    .reset           (reset),
    .adc_valid       (adc_valid),
    .adc_data        (adc_data),
    .cfg_valid       (cfg_valid),
    .cfg             (cfg),
    .stop_aux        (stop_aux),
    .out             (out),
    .out_ready       (out_ready),
    .capture_started (capture_started),
    .buffer_full     (buffer_full)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic fail_value(input string msg);
    err_count++;
    $display("TB FAILED");
    $display("ERR %0t ns: %s", $time, msg);
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_plain(input string msg);
    err_count++;
    $display("TB FAILED");
    $display("%s", msg);
    $fatal(1, "stopped at the first error");
  endtask

  // the assertions look at a plain copy of the queue head
  function automatic void refresh_front();
    exp_avail = (exp_q.size() > 0);
    exp_front = exp_avail ? exp_q[0] : '0;
  endfunction

  always @(posedge clk) begin
    if (!reset && out.valid && out_ready && exp_avail) begin
      void'(exp_q.pop_front());
      refresh_front();
    end
  end

  // outputs come out of reset quiet
  assert property (@(posedge clk) $fell(reset) |->
    !out.valid && !out.last && !capture_started && !buffer_full)
    else fail_value("outputs not low after reset");

  // capture_started follows a start request by one cycle and lasts one cycle
  assert property (@(posedge clk) disable iff (reset)
    capture_started == $past(cfg_valid && cfg.start))
    else fail_value("capture_started does not follow the start request");
  assert property (@(posedge clk) disable iff (reset)
    capture_started |=> !capture_started)
    else fail_value("capture_started longer than one cycle");

  assert property (@(posedge clk) disable iff (reset)
    out.valid && out_ready |-> exp_avail)
    else fail_plain("the DUT sent a word that the model did not predict");
  assert property (@(posedge clk) disable iff (reset)
    out.valid && out_ready && exp_avail |-> out.data.header == exp_front.data)
    else fail_value($sformatf("data %h, expected %h",
                              $sampled(out.data.header), $sampled(exp_front.data)));
  assert property (@(posedge clk) disable iff (reset)
    out.valid && out_ready && exp_avail |-> out.last == exp_front.last)
    else fail_value($sformatf("last %b, expected %b",
                              $sampled(out.last), $sampled(exp_front.last)));

  // a stalled word must not change before it is taken
  assert property (@(posedge clk) disable iff (reset)
    out.valid && !out_ready |=> out.valid && $stable(out.data) && $stable(out.last))
    else fail_value("output changed while ready was low");

  function automatic sample_word_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic clear_model();
    for (int c = 0; c < CHANNELS; c++) begin
      sent_q[c].delete();
    end
  endtask

  task automatic send_config(input int mode, input bit do_start, input bit do_stop);
    @(negedge clk);
    cfg_valid = 1'b1;
    cfg       = '{banking_mode: MODE_WIDTH'(mode), start: do_start, stop: do_stop};
    @(negedge clk);
    cfg_valid = 1'b0;
    cfg       = '0;
  endtask

  // each channel sends its own number of words with random gaps
  task automatic send_counts(input int counts[CHANNELS]);
    int left[CHANNELS];
    int busy;
    int guard;
    left  = counts;
    guard = 0;
    do begin
      @(negedge clk);
      busy = 0;
      for (int c = 0; c < CHANNELS; c++) begin
        adc_data[c]  = random_word();
        adc_valid[c] = (left[c] > 0) && (($random(seed) & 1) != 0);
        if (adc_valid[c]) begin
          sent_q[c].push_back(adc_data[c]);
          left[c]--;
        end
        busy += left[c];
      end
      guard++;
      if (guard > TIMEOUT) begin
        fail_plain("timeout while sending the channel words");
      end
    end while (busy > 0);
    @(negedge clk);
    adc_valid = '0;
  endtask

  // every channel streams but only channel 0 counts in single-channel mode
  task automatic stream_until_full();
    int guard;
    guard = 0;
    while (!buffer_full) begin
      @(negedge clk);
      for (int c = 0; c < CHANNELS; c++) begin
        adc_valid[c] = 1'b1;
        adc_data[c]  = random_word();
      end
      sent_q[0].push_back(adc_data[0]);
      guard++;
      if (guard > TIMEOUT) begin
        fail_plain("timeout waiting for buffer_full");
      end
    end
    @(negedge clk);
    adc_valid = '0;
  endtask

  // words presented together with or after the stop_aux edge must not be stored
  task automatic stream_until_aux(input int n_active, input int stop_cycle, input int extra);
    for (int cyc = 0; cyc < stop_cycle + extra; cyc++) begin
      @(negedge clk);
      if (cyc == stop_cycle) begin
        stop_aux = 1'b1;
      end
      for (int c = 0; c < CHANNELS; c++) begin
        adc_data[c]  = random_word();
        adc_valid[c] = ($random(seed) & 3) != 0;
        if (adc_valid[c] && c < n_active && cyc < stop_cycle) begin
          sent_q[c].push_back(adc_data[c]);
        end
      end
    end
    @(negedge clk);
    adc_valid = '0;
    stop_aux  = 1'b0;
  endtask

  // bank i serves channel i mod n_active and holds that channel's words
  // from (i / n_active) * BUFFER_DEPTH onwards, at most BUFFER_DEPTH of them
  task automatic build_expected(input int n_active);
    int ch;
    int base;
    int cnt;
    for (int i = 0; i < CHANNELS; i++) begin
      ch   = i % n_active;
      base = (i / n_active) * BUFFER_DEPTH;
      cnt  = sent_q[ch].size() - base;
      if (cnt < 0) begin
        cnt = 0;
      end
      if (cnt > BUFFER_DEPTH) begin
        cnt = BUFFER_DEPTH;
      end
      exp_q.push_back(expect_t'{data: WORD_WIDTH'(ch), last: 1'b0});
      exp_q.push_back(expect_t'{data: WORD_WIDTH'(cnt), last: 1'b0});
      for (int j = 0; j < cnt; j++) begin
        exp_q.push_back(expect_t'{data: sent_q[ch][base + j], last: 1'b0});
      end
    end
    // only the final word of the final bank ends the stream
    exp_q[exp_q.size() - 1].last = 1'b1;
    refresh_front();
  endtask

  task automatic wait_readout(input bit random_ready);
    int guard;
    guard = 0;
    while (exp_avail) begin
      @(negedge clk);
      out_ready = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
      guard++;
      if (guard > TIMEOUT) begin
        fail_plain("timeout waiting for the readout to finish");
      end
    end
    // ready stays high a little longer so a surplus word would be caught
    @(negedge clk);
    out_ready = 1'b1;
    repeat (10) @(negedge clk);
    out_ready = 1'b0;
  endtask

  // four channels with random word counts below the bank depth and one silent channel
  task automatic run_four_channel(input int idle, input bit random_ready);
    int counts[CHANNELS];
    clear_model();
    for (int c = 0; c < CHANNELS; c++) begin
      counts[c] = (c == idle) ? 0 : 1 + (($random(seed) & 32'h7fff_ffff) % (BUFFER_DEPTH - 1));
    end
    send_config(2, 1'b1, 1'b0);
    send_counts(counts);
    send_config(2, 1'b0, 1'b1);
    build_expected(4);
    wait_readout(random_ready);
  endtask

  initial begin
    seed      = 64557;
    err_count = 0;
    reset     = 1'b1;
    adc_valid = '0;
    adc_data  = '0;
    cfg_valid = 1'b0;
    cfg       = '0;
    stop_aux  = 1'b0;
    out_ready = 1'b0;
    exp_q.delete();
    refresh_front();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // channel 3 stays silent, so the stream ends on its zero count word
    run_four_channel(3, 1'b0);

    // one channel runs through all four banks until the last one fills
    clear_model();
    send_config(0, 1'b1, 1'b0);
    stream_until_full();
    build_expected(1);
    wait_readout(1'b0);

    // two channels, cut off by stop_aux in the middle of the stream
    clear_model();
    send_config(1, 1'b1, 1'b0);
    stream_until_aux(2, 15, 6);
    build_expected(2);
    wait_readout(1'b0);

    // same as the first round but the sink stalls at random
    run_four_channel(1, 1'b1);

    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
sample_buffer_pkg.sv
sample_buffer_bank.sv
capture_control.sv
bank_input_router.sv
readout_mux.sv
sample_buffer.sv
sample_buffer_tb.sv
